/* compile.f */
+incdir+src
src/ntt_gs_pkg.sv
src/ntt_seq_if.sv
src/ntt_addr_gen.sv
src/ntt_flight_ctrl.sv
src/ntt_gs_ctrl.sv
src/ntt_gs_core.sv
verif/ntt_gs_chk.sv
verif/ntt_gs_tb.sv

/* Makefile */
# Verilator simulation of the inverse NTT controller

VERILATOR := verilator
VFLAGS    := --binary --assert --timing -Wno-fatal -j 0
TOP       := ntt_gs_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

/* verif/ntt_gs_tb.sv */
/*
  Directed testbench for the inverse NTT controller. The butterfly is an
  in-order pipe with a fixed latency of 10 or a random one of 1 to 12 cycles
*/
`timescale 1ns/10ps
`include "ntt_gs_defines.svh"

module ntt_gs_tb;

  import ntt_gs_pkg::*;

  localparam int AW       = `NTT_ADDR_W;
  localparam int WORDS    = `NTT_WORDS;
  localparam int GS_OPS   = `NTT_GS_ROUNDS * `NTT_WORDS;
  localparam int CLK_HALF = 2;
  localparam int FIX_LAT  = 10;
  // Five runs of four rounds with 64 operations of 16 cycles each
  localparam int WATCHDOG_CYCLES = 5 * `NTT_GS_ROUNDS * `NTT_WORDS * 16;

  logic                      pi_clk = 1'b0;
  logic                      pi_reset_n;
  logic                      zeroize;
  logic                      ntt_enable;
  ntt_mode_e                 mode;
  logic [3*AW-1:0]           base_addr;
  logic                      butterfly_ready = 1'b0;
  logic                      mem_rd_en;
  logic [AW-1:0]             mem_rd_addr;
  logic [AW-1:0]             mem_rd_addr_b;
  logic [`NTT_TWIDDLE_W-1:0] twiddle_addr;
  logic                      bf_enable;
  logic [1:0]                buf_wrptr;
  logic                      mem_wr_en;
  logic [AW-1:0]             mem_wr_addr;
  logic                      busy;
  logic                      done;

  // Butterfly model
  integer seed = 32'h242a;
  bit     random_latency = 1'b0;
  bit     zero_seen = 1'b0;
  int     cycle_count = 0;
  int     last_due = 0;
  int     due_q[$];

  // Access logs and counters
  logic [AW-1:0]             rd_log[$];
  logic [AW-1:0]             rd_b_log[$];
  logic [`NTT_TWIDDLE_W-1:0] tw_log[$];
  logic [AW-1:0]             wr_log[$];
  logic [1:0]                ptr_log[$];
  int done_count = 0;
  int check_count = 0;
  int error_count = 0;
  int assert_count;

  ntt_gs_core i_ntt_gs_core (.*);

  initial begin
    forever #CLK_HALF pi_clk = ~pi_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("Watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

  // ------------------------------
  // Butterfly and monitor
  // ------------------------------
  always @(posedge pi_clk) zero_seen <= zeroize;

  // Results return in issue order and at most one per cycle
  always @(negedge pi_clk) begin
    int due;
    cycle_count = cycle_count + 1;
    if (!pi_reset_n || zero_seen) begin
      due_q.delete();
      butterfly_ready = 1'b0;
    end else begin
      butterfly_ready = (due_q.size() > 0) && (due_q[0] == cycle_count);
      if (butterfly_ready) begin
        void'(due_q.pop_front());
      end
      if (bf_enable) begin
        due = cycle_count + (random_latency ? 1 + ($unsigned($random(seed)) % 12) : FIX_LAT);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        due_q.push_back(due);
        last_due = due;
      end
    end
  end

  always @(negedge pi_clk) begin
    if (pi_reset_n && mem_rd_en) begin
      rd_log.push_back(mem_rd_addr);
      rd_b_log.push_back(mem_rd_addr_b);
      tw_log.push_back(twiddle_addr);
    end
    if (pi_reset_n && mem_wr_en) begin
      wr_log.push_back(mem_wr_addr);
      ptr_log.push_back(buf_wrptr);
    end
    if (pi_reset_n && done) begin
      done_count = done_count + 1;
    end
  end

  // ------------------------------
  // Checks and expected values
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  function automatic int gs_read_base(input int r, input int src, input int interim,
                                      input int dest);
    if (r == 0) begin
      return src;
    end
    return (r == 2) ? dest : interim;
  endfunction

  // Each round's table follows the previous one and is a quarter its size
  function automatic int gs_twiddle(input int r, input int i);
    int offset;
    int k;
    offset = 0;
    for (k = 0; k < r; k++) begin
      offset += WORDS >> (2 * k);
    end
    return offset + (i >> (2 * r));
  endfunction

  task automatic start_run(input ntt_mode_e run_mode, input logic [3*AW-1:0] bases);
    @(negedge pi_clk);
    mode = run_mode;
    base_addr = bases;
    rd_log.delete();
    rd_b_log.delete();
    tw_log.delete();
    wr_log.delete();
    ptr_log.delete();
    done_count = 0;
    ntt_enable = 1'b1;
    @(negedge pi_clk);
    ntt_enable = 1'b0;
    check_value("busy", busy, 1);
  endtask

  task automatic wait_done();
    while (done !== 1'b1) begin
      @(negedge pi_clk);
    end
    check_value("busy", busy, 0);
    repeat (4) @(negedge pi_clk);
    check_value("done pulse count", done_count, 1);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic expect_reset_outputs();
    @(negedge pi_clk);
    check_value("mem_rd_en", mem_rd_en, 0);
    check_value("mem_rd_addr", mem_rd_addr, 0);
    check_value("mem_rd_addr_b", mem_rd_addr_b, 0);
    check_value("twiddle_addr", twiddle_addr, 0);
    check_value("bf_enable", bf_enable, 0);
    check_value("buf_wrptr", buf_wrptr, 0);
    check_value("mem_wr_en", mem_wr_en, 0);
    check_value("mem_wr_addr", mem_wr_addr, 0);
    check_value("busy", busy, 0);
    check_value("done", done, 0);
  endtask

  task automatic transform_gs(input int src, input int interim, input int dest);
    int n;
    int r;
    int idx;
    int wbase;
    start_run(gs, {AW'(src), AW'(interim), AW'(dest)});
    wait_done();
    check_value("read count", rd_log.size(), GS_OPS);
    check_value("write count", wr_log.size(), GS_OPS);
    for (n = 0; n < rd_log.size() && n < GS_OPS; n++) begin
      r = n / WORDS;
      idx = n % WORDS;
      check_value("mem_rd_addr", rd_log[n], gs_read_base(r, src, interim, dest) + idx);
      check_value("twiddle_addr", tw_log[n], gs_twiddle(r, idx));
    end
    // Writes land transposed and j mod 4 selects a 16-word column
    for (n = 0; n < wr_log.size() && n < GS_OPS; n++) begin
      r = n / WORDS;
      idx = n % WORDS;
      wbase = (r % 2 == 1) ? dest : interim;
      check_value("mem_wr_addr", wr_log[n], wbase + (idx % 4) * 16 + idx / 4);
      check_value("buf_wrptr", ptr_log[n], n % 4);
    end
  endtask

  task automatic multiply_pointwise(input int a, input int b, input int c);
    int n;
    start_run(pwo, {AW'(a), AW'(b), AW'(c)});
    wait_done();
    check_value("read count", rd_log.size(), WORDS);
    check_value("write count", wr_log.size(), WORDS);
    for (n = 0; n < rd_log.size() && n < WORDS; n++) begin
      check_value("mem_rd_addr", rd_log[n], a + n);
      check_value("mem_rd_addr_b", rd_b_log[n], b + n);
      check_value("twiddle_addr", tw_log[n], 0);
    end
    for (n = 0; n < wr_log.size() && n < WORDS; n++) begin
      check_value("mem_wr_addr", wr_log[n], c + n);
      check_value("buf_wrptr", ptr_log[n], n % 4);
    end
  endtask

  task automatic abort_with_zeroize();
    int k;
    start_run(gs, {AW'('h0900), AW'('h0a00), AW'('h0b00)});
    repeat (150) @(negedge pi_clk);
    check_value("busy", busy, 1);
    zeroize = 1'b1;
    @(negedge pi_clk);
    zeroize = 1'b0;
    for (k = 0; k < 6; k++) begin
      check_value("busy", busy, 0);
      check_value("mem_rd_en", mem_rd_en, 0);
      check_value("bf_enable", bf_enable, 0);
      @(negedge pi_clk);
    end
    check_value("done pulse count", done_count, 0);
    transform_gs('h0c00, 'h0d00, 'h0e00);
  endtask

  initial begin
    pi_reset_n = 1'b0;
    zeroize = 1'b0;
    ntt_enable = 1'b0;
    mode = gs;
    base_addr = '0;
    repeat (5) @(negedge pi_clk);
    pi_reset_n = 1'b1;
    expect_reset_outputs();
    random_latency = 1'b0;
    transform_gs('h0100, 'h0200, 'h0300);
    random_latency = 1'b1;
    transform_gs('h1000, 'h2040, 'h7f00);
    multiply_pointwise('h0400, 'h0500, 'h0600);
    random_latency = 1'b0;
    abort_with_zeroize();
    assert_count = i_ntt_gs_core.i_ntt_gs_chk.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, assert_count);
    if (error_count == 0 && assert_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verif/ntt_gs_chk.sv */
/*
  Protocol checks on the controller outputs, bound into ntt_gs_core.
  Expects butterfly_ready only for reads already issued
*/
`timescale 1ns/10ps
`include "ntt_gs_defines.svh"

module ntt_gs_chk (
  input logic                      pi_clk,
  input logic                      pi_reset_n,
  input logic                      zeroize,
  input logic                      butterfly_ready,
  input logic                      mem_rd_en,
  input logic [`NTT_ADDR_W-1:0]    mem_rd_addr,
  input logic [`NTT_ADDR_W-1:0]    mem_rd_addr_b,
  input logic [`NTT_TWIDDLE_W-1:0] twiddle_addr,
  input logic                      bf_enable,
  input logic [1:0]                buf_wrptr,
  input logic                      mem_wr_en,
  input logic [`NTT_ADDR_W-1:0]    mem_wr_addr,
  input logic                      busy,
  input logic                      done
);

  int         fail_count = 0;
  logic [3:0] outstanding;
  logic       outputs_zero;

  // Reads issued and not yet answered by the butterfly
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      outstanding <= '0;
    end else if (zeroize) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 4'(mem_rd_en) - 4'(butterfly_ready);
    end
  end

  assign outputs_zero = !mem_rd_en && !bf_enable && !mem_wr_en && !busy && !done &&
                        (mem_rd_addr == '0) && (mem_rd_addr_b == '0) &&
                        (mem_wr_addr == '0) && (twiddle_addr == '0) && (buf_wrptr == '0);

  // ------------------------------
  // Assertions
  // ------------------------------
  a_rd_to_bf: assert property (@(posedge pi_clk) disable iff (!pi_reset_n || zeroize)
    mem_rd_en |=> bf_enable)
    else begin
      $error("bf_enable missing one cycle after mem_rd_en");
      fail_count++;
    end

  a_bf_from_rd: assert property (@(posedge pi_clk) disable iff (!pi_reset_n || zeroize)
    bf_enable |-> $past(mem_rd_en))
    else begin
      $error("bf_enable without a read in the cycle before");
      fail_count++;
    end

  a_inflight: assert property (@(posedge pi_clk) disable iff (!pi_reset_n)
    outstanding <= 4'(`NTT_MAX_INFLIGHT))
    else begin
      $error("more than four butterfly operations outstanding");
      fail_count++;
    end

  a_done_pulse: assert property (@(posedge pi_clk) disable iff (!pi_reset_n)
    done |=> !done)
    else begin
      $error("done is longer than one cycle");
      fail_count++;
    end

  a_done_busy: assert property (@(posedge pi_clk) disable iff (!pi_reset_n)
    done |-> $fell(busy))
    else begin
      $error("done without busy falling");
      fail_count++;
    end

  // Zeroize is the only other way out of a run
  a_busy_fall: assert property (@(posedge pi_clk) disable iff (!pi_reset_n)
    $fell(busy) |-> (done || $past(zeroize)))
    else begin
      $error("busy fell without done");
      fail_count++;
    end

  a_reset_values: assert property (@(posedge pi_clk)
    $rose(pi_reset_n) |-> outputs_zero)
    else begin
      $error("outputs not zero in the first cycle after reset");
      fail_count++;
    end

endmodule

bind ntt_gs_core ntt_gs_chk i_ntt_gs_chk (.*);

/* src/ntt_gs_core.sv */
/*
  Inverse NTT and pointwise controller top. Butterfly results return in
  order on butterfly_ready; mode and base_addr stay stable while busy
*/
`timescale 1ns/10ps
`include "ntt_gs_defines.svh"

module ntt_gs_core (
  input  logic                       pi_clk,
  input  logic                       pi_reset_n,
  input  logic                       zeroize,
  input  logic                       ntt_enable,
  input  ntt_gs_pkg::ntt_mode_e      mode,
  input  logic [3*`NTT_ADDR_W-1:0]   base_addr,
  input  logic                       butterfly_ready,
  output logic                       mem_rd_en,
  output logic [`NTT_ADDR_W-1:0]     mem_rd_addr,
  output logic [`NTT_ADDR_W-1:0]     mem_rd_addr_b,
  output logic [`NTT_TWIDDLE_W-1:0]  twiddle_addr,
  output logic                       bf_enable,
  output logic [1:0]                 buf_wrptr,
  output logic                       mem_wr_en,
  output logic [`NTT_ADDR_W-1:0]     mem_wr_addr,
  output logic                       busy,
  output logic                       done
);

  ntt_seq_if i_seq ();

  // Address generator and flight tracker run side by side
  ntt_addr_gen i_addr_gen (
    .pi_clk        (pi_clk),
    .pi_reset_n    (pi_reset_n),
    .zeroize       (zeroize),
    .mode          (mode),
    .base_addr     (base_addr),
    .seq           (i_seq.addr),
    .mem_rd_addr   (mem_rd_addr),
    .mem_rd_addr_b (mem_rd_addr_b),
    .mem_wr_addr   (mem_wr_addr),
    .twiddle_addr  (twiddle_addr)
  );

  ntt_flight_ctrl i_flight_ctrl (
    .pi_clk          (pi_clk),
    .pi_reset_n      (pi_reset_n),
    .zeroize         (zeroize),
    .bf_enable       (bf_enable),
    .butterfly_ready (butterfly_ready),
    .seq             (i_seq.flight),
    .buf_wrptr       (buf_wrptr)
  );

  // Sequencer combines both into enables and status
  ntt_gs_ctrl i_gs_ctrl (
    .pi_clk     (pi_clk),
    .pi_reset_n (pi_reset_n),
    .zeroize    (zeroize),
    .ntt_enable (ntt_enable),
    .mode       (mode),
    .seq        (i_seq.ctrl),
    .mem_rd_en  (mem_rd_en),
    .bf_enable  (bf_enable),
    .mem_wr_en  (mem_wr_en),
    .busy       (busy),
    .done       (done)
  );

endmodule

/* src/ntt_gs_ctrl.sv */
/*
  Round sequencer. ntt_enable is ignored while busy; mode must hold for the
  whole run. Four rounds in gs mode, one in pwo mode
*/
`timescale 1ns/10ps
`include "ntt_gs_defines.svh"

module ntt_gs_ctrl (
  input  logic                  pi_clk,
  input  logic                  pi_reset_n,
  input  logic                  zeroize,
  input  logic                  ntt_enable,
  input  ntt_gs_pkg::ntt_mode_e mode,
  ntt_seq_if.ctrl               seq,
  output logic                  mem_rd_en,
  output logic                  bf_enable,
  output logic                  mem_wr_en,
  output logic                  busy,
  output logic                  done
);

  import ntt_gs_pkg::*;

  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_load   = 2'd1;
  localparam logic [1:0] st_run    = 2'd2;
  localparam logic [1:0] st_finish = 2'd3;

  logic [1:0] state;
  logic [1:0] round_q;
  logic [1:0] last_round;
  logic       round_end;

  assign last_round = (mode == pwo) ? 2'd0 : 2'(`NTT_GS_ROUNDS - 1);

  // Every result is back once index 63 is written
  assign round_end = seq.wr_last && seq.empty;

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      state     <= st_idle;
      round_q   <= '0;
      bf_enable <= 1'b0;
    end else if (zeroize) begin
      state     <= st_idle;
      round_q   <= '0;
      bf_enable <= 1'b0;
    end else begin
      // Memory returns data one cycle after the read
      bf_enable <= seq.rd_issue;
      case (state)
        st_idle: begin
          if (ntt_enable) begin
            round_q <= '0;
            state   <= st_load;
          end
        end
        st_load: begin
          state <= st_run;
        end
        st_run: begin
          if (round_end) begin
            if (round_q == last_round) begin
              state <= st_finish;
            end else begin
              round_q <= round_q + 1'b1;
              state   <= st_load;
            end
          end
        end
        default: begin
          // Busy is already low in the done cycle so a new run may start
          if (ntt_enable) begin
            round_q <= '0;
            state   <= st_load;
          end else begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // ------------------------------
  // Strobes and status
  // ------------------------------
  assign seq.start    = (state == st_load);
  assign seq.round    = round_q;
  assign seq.rd_issue = (state == st_run) && !seq.rd_last && !seq.full;

  assign mem_rd_en = seq.rd_issue;
  assign mem_wr_en = seq.wr_issue;
  assign busy      = (state == st_load) || (state == st_run);
  assign done      = (state == st_finish);

endmodule

/* src/ntt_flight_ctrl.sv */
/*
  Butterfly occupancy tracker. Results must come back in issue order and
  never before the enable that caused them
*/
`timescale 1ns/10ps
`include "ntt_gs_defines.svh"

module ntt_flight_ctrl (
  input  logic       pi_clk,
  input  logic       pi_reset_n,
  input  logic       zeroize,
  input  logic       bf_enable,
  input  logic       butterfly_ready,
  ntt_seq_if.flight  seq,
  output logic [1:0] buf_wrptr
);

  localparam int CNT_W = $clog2(`NTT_MAX_INFLIGHT) + 1;

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] pending;

  // ------------------------------
  // Outstanding operations
  // ------------------------------
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      count <= '0;
    end else if (zeroize) begin
      count <= '0;
    end else if (bf_enable != butterfly_ready) begin
      count <= bf_enable ? count + 1'b1 : count - 1'b1;
    end
  end

  // A read issued last cycle is not counted yet but shows as bf_enable now
  assign pending   = count + CNT_W'(bf_enable);
  assign seq.full  = (pending >= CNT_W'(`NTT_MAX_INFLIGHT));
  assign seq.empty = (count == '0);

  // ------------------------------
  // Result write strobe and slot
  // ------------------------------
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      seq.wr_issue <= 1'b0;
      buf_wrptr    <= '0;
    end else if (zeroize) begin
      seq.wr_issue <= 1'b0;
      buf_wrptr    <= '0;
    end else begin
      seq.wr_issue <= butterfly_ready;
      // Slot shows the result being written, then moves on
      if (seq.start) begin
        buf_wrptr <= '0;
      end else if (seq.wr_issue) begin
        buf_wrptr <= buf_wrptr + 1'b1;
      end
    end
  end

endmodule

/* src/ntt_addr_gen.sv */
/*
  Registered read, write and twiddle addresses. Outputs hold the address of
  the next access; bases are read directly and must not change within a run
*/
`timescale 1ns/10ps
`include "ntt_gs_defines.svh"

module ntt_addr_gen (
  input  logic                       pi_clk,
  input  logic                       pi_reset_n,
  input  logic                       zeroize,
  input  ntt_gs_pkg::ntt_mode_e      mode,
  input  ntt_gs_pkg::ntt_base_addr_u base_addr,
  ntt_seq_if.addr                    seq,
  output logic [`NTT_ADDR_W-1:0]     mem_rd_addr,
  output logic [`NTT_ADDR_W-1:0]     mem_rd_addr_b,
  output logic [`NTT_ADDR_W-1:0]     mem_wr_addr,
  output logic [`NTT_TWIDDLE_W-1:0]  twiddle_addr
);

  import ntt_gs_pkg::*;

  localparam int IDX_W = $clog2(`NTT_WORDS);

  // Read index needs one extra bit to flag the end of a round
  logic [IDX_W:0]              rd_idx;
  logic [IDX_W:0]              rd_next;
  logic [IDX_W-1:0]            wr_idx;
  logic [IDX_W-1:0]            wr_next;
  logic [`NTT_ADDR_W-1:0]      rd_base;
  logic [`NTT_ADDR_W-1:0]      rd_base_b;
  logic [`NTT_ADDR_W-1:0]      wr_base;
  logic [`NTT_ADDR_W-1:0]      wr_off;
  logic [`NTT_TWIDDLE_W-1:0]   tw_base;
  logic [`NTT_TWIDDLE_W-1:0]   tw_next;

  // ------------------------------
  // Base selection
  // ------------------------------
  always_comb begin
    if (mode == pwo) begin
      rd_base   = base_addr.pwo_bases.a;
      rd_base_b = base_addr.pwo_bases.b;
      wr_base   = base_addr.pwo_bases.c;
    end else begin
      // src -> interim -> dest -> interim -> dest
      case (seq.round)
        2'd0:    rd_base = base_addr.gs_bases.src;
        2'd2:    rd_base = base_addr.gs_bases.dest;
        default: rd_base = base_addr.gs_bases.interim;
      endcase
      rd_base_b = '0;
      wr_base   = seq.round[0] ? base_addr.gs_bases.dest : base_addr.gs_bases.interim;
    end
  end

  // Twiddle table offsets per round over 64 + 16 + 4 + 1 entries
  always_comb begin
    case (seq.round)
      2'd0:    tw_base = 7'd0;
      2'd1:    tw_base = 7'd64;
      2'd2:    tw_base = 7'd80;
      default: tw_base = 7'd84;
    endcase
  end

  // ------------------------------
  // Next indices and offsets
  // ------------------------------
  assign rd_next = seq.start ? '0 : rd_idx + 1'b1;
  assign wr_next = seq.start ? '0 : wr_idx + 1'b1;

  // Transposed write where j mod 4 picks the 16-word column
  assign wr_off = (mode == pwo) ? `NTT_ADDR_W'(wr_next)
                                : `NTT_ADDR_W'({wr_next[1:0], 4'b0000}) +
                                  `NTT_ADDR_W'(wr_next[IDX_W-1:2]);

  assign tw_next = (mode == pwo) ? '0
                                 : tw_base + `NTT_TWIDDLE_W'(rd_next >> {seq.round, 1'b0});

  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      rd_idx        <= '0;
      wr_idx        <= '0;
      mem_rd_addr   <= '0;
      mem_rd_addr_b <= '0;
      mem_wr_addr   <= '0;
      twiddle_addr  <= '0;
    end else if (zeroize) begin
      rd_idx        <= '0;
      wr_idx        <= '0;
      mem_rd_addr   <= '0;
      mem_rd_addr_b <= '0;
      mem_wr_addr   <= '0;
      twiddle_addr  <= '0;
    end else begin
      if (seq.start || seq.rd_issue) begin
        rd_idx        <= rd_next;
        mem_rd_addr   <= rd_base + `NTT_ADDR_W'(rd_next);
        mem_rd_addr_b <= (mode == pwo) ? rd_base_b + `NTT_ADDR_W'(rd_next) : '0;
        twiddle_addr  <= tw_next;
      end
      if (seq.start || seq.wr_issue) begin
        wr_idx      <= wr_next;
        mem_wr_addr <= wr_base + wr_off;
      end
    end
  end

  assign seq.rd_last = rd_idx[IDX_W];
  assign seq.wr_last = seq.wr_issue && (wr_idx == IDX_W'(`NTT_WORDS - 1));

endmodule

/* src/ntt_seq_if.sv */
/*
  Sequencing strobes between round sequencer, address generator and
  flight tracker. Strobes last one cycle and all signals are sampled on pi_clk
*/
`timescale 1ns/10ps

interface ntt_seq_if;

  // Round control from the sequencer
  logic       start;
  logic [1:0] round;
  logic       rd_issue;

  // Index status from the address generator
  logic       rd_last;
  logic       wr_last;

  // Butterfly occupancy from the flight tracker
  logic       wr_issue;
  logic       full;
  logic       empty;

  modport ctrl (
    output start, round, rd_issue,
    input  rd_last, wr_last, wr_issue, full, empty
  );

  modport addr (
    input  start, round, rd_issue, wr_issue,
    output rd_last, wr_last
  );

  modport flight (
    input  start,
    output wr_issue, full, empty
  );

endinterface

/* src/ntt_gs_pkg.sv */
/*
  Mode and base-address types. One 45-bit base word is shared by both modes,
  so the caller must set it for the mode it selects
*/
`include "ntt_gs_defines.svh"

package ntt_gs_pkg;

  // ------------------------------
  // Operating mode
  // ------------------------------
  typedef enum logic {
    gs  = 1'b0,   // Inverse transform in Gentleman-Sande order
    pwo = 1'b1    // Pointwise multiply
  } ntt_mode_e;

  // ------------------------------
  // Base addresses
  // ------------------------------
  // Inverse transform view where rounds ping-pong between interim and dest
  typedef struct packed {
    logic [`NTT_ADDR_W-1:0] src;
    logic [`NTT_ADDR_W-1:0] interim;
    logic [`NTT_ADDR_W-1:0] dest;
  } ntt_bases_s;

  // Pointwise view computing c = a * b word by word
  typedef struct packed {
    logic [`NTT_ADDR_W-1:0] a;
    logic [`NTT_ADDR_W-1:0] b;
    logic [`NTT_ADDR_W-1:0] c;
  } pwo_bases_s;

  // Same word decoded by mode
  typedef union packed {
    ntt_bases_s gs_bases;
    pwo_bases_s pwo_bases;
  } ntt_base_addr_u;

endpackage

/* src/ntt_gs_defines.svh */
/*
  Sizes for the inverse NTT controller. Address width must hold base + 63
  for every base in use; the twiddle width covers the 85 inverse entries
*/
`ifndef NTT_GS_DEFINES_SVH
`define NTT_GS_DEFINES_SVH

// ------------------------------
// Memory layout
// ------------------------------
`define NTT_ADDR_W 15

// Four coefficients per word, 256 coefficients per polynomial
`define NTT_WORDS 64

// ------------------------------
// Sequencing
// ------------------------------
// Radix-4 rounds of the inverse transform
`define NTT_GS_ROUNDS 4

// Butterfly operations allowed in flight at once
`define NTT_MAX_INFLIGHT 4

`define NTT_TWIDDLE_W 7

`endif
